//--- verilog/sub_mult_pkg.sv
package sub_mult_pkg;

  // Word width of data, grid, scale and result
  localparam int WORD_W = 16;

  // Default fixed-point formats
  localparam int FRAC_DATA  = 12;
  localparam int FRAC_SCALE = 12;
  localparam int FRAC_RSLT  = 12;

  // Input streams and their lane positions
  localparam int NUM_LANES  = 3;
  localparam int LANE_DATA  = 0;
  localparam int LANE_GRID  = 1;
  localparam int LANE_SCALE = 2;

  // Signed fixed-point word
  typedef logic signed [WORD_W-1:0] word_t;

endpackage

//--- verilog/beat_if.sv
interface beat_if #(
  parameter int DATA_W = $bits(sub_mult_pkg::word_t)
);

  logic [DATA_W-1:0] tdata;
  logic              tvalid;
  logic              tready;
  logic              tlast;

  // Sender side
  modport src (
    output tdata,
    output tvalid,
    output tlast,
    input  tready
  );

  // Receiver side
  modport dst (
    input  tdata,
    input  tvalid,
    input  tlast,
    output tready
  );

endinterface

//--- verilog/axis_skid.sv
module axis_skid #(
  parameter int DATA_W = 16
) (
  input  logic clk,
  input  logic arst_n,
  beat_if.dst  in,
  beat_if.src  out
);

  logic              in_ready_q;
  logic              ready_early;
  logic              out_valid_q;
  logic              out_valid_d;
  logic              temp_valid_q;
  logic              temp_valid_d;
  logic              store_in_to_out;
  logic              store_in_to_temp;
  logic              store_temp_to_out;
  logic [DATA_W-1:0] out_data_q;
  logic              out_last_q;
  logic [DATA_W-1:0] temp_data_q;
  logic              temp_last_q;

  assign in.tready  = in_ready_q;
  assign out.tdata  = out_data_q;
  assign out.tvalid = out_valid_q;
  assign out.tlast  = out_last_q;

  // Ready for next cycle, predicted from whether the skid entry will be free
  assign ready_early = out.tready || (!temp_valid_q && (!out_valid_q || !in.tvalid));

  always_comb begin
    out_valid_d       = out_valid_q;
    temp_valid_d      = temp_valid_q;
    store_in_to_out   = 1'b0;
    store_in_to_temp  = 1'b0;
    store_temp_to_out = 1'b0;
    if (in_ready_q) begin
      if (out.tready || !out_valid_q) begin
        out_valid_d     = in.tvalid;
        store_in_to_out = 1'b1;
      end else begin
        // Output stalled, park the incoming beat
        temp_valid_d     = in.tvalid;
        store_in_to_temp = 1'b1;
      end
    end else if (out.tready) begin
      out_valid_d       = temp_valid_q;
      temp_valid_d      = 1'b0;
      store_temp_to_out = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_ready_q   <= 1'b0;
      out_valid_q  <= 1'b0;
      temp_valid_q <= 1'b0;
    end else begin
      in_ready_q   <= ready_early;
      out_valid_q  <= out_valid_d;
      temp_valid_q <= temp_valid_d;
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (store_in_to_out) begin
      out_data_q <= in.tdata;
      out_last_q <= in.tlast;
    end else if (store_temp_to_out) begin
      out_data_q <= temp_data_q;
      out_last_q <= temp_last_q;
    end
    if (store_in_to_temp) begin
      temp_data_q <= in.tdata;
      temp_last_q <= in.tlast;
    end
  end

endmodule

//--- verilog/frame_lane.sv
module frame_lane #(
  parameter int DATA_W = 16
) (
  input  logic clk,
  input  logic arst_n,
  beat_if.dst  in,
  input  logic frame_done,
  beat_if.src  out
);

  logic hold;

  beat_if #(.DATA_W(DATA_W)) skid_in ();

  // Final beat sits at the output until the joined frame closes
  assign hold = out.tvalid && out.tlast && !frame_done;

  // In hold the lane loops its own output back into the skid register.
  // Reload only when the held beat is taken, so no copy lands in the skid entry
  assign skid_in.tdata  = hold ? out.tdata : in.tdata;
  assign skid_in.tlast  = hold ? out.tlast : in.tlast;
  assign skid_in.tvalid = hold ? out.tready : in.tvalid;

  // Next frame waits for frame_done
  assign in.tready = hold ? 1'b0 : skid_in.tready;

  axis_skid #(
    .DATA_W(DATA_W)
  ) u_skid (
    .clk   (clk),
    .arst_n(arst_n),
    .in    (skid_in.dst),
    .out   (out)
  );

endmodule

//--- verilog/sub_mult_join.sv
module sub_mult_join #(
  parameter int FRAC_DATA  = sub_mult_pkg::FRAC_DATA,
  parameter int FRAC_SCALE = sub_mult_pkg::FRAC_SCALE,
  parameter int FRAC_RSLT  = sub_mult_pkg::FRAC_RSLT
) (
  input  logic                clk,
  input  logic                arst_n,
  beat_if.dst                 data,
  beat_if.dst                 grid,
  beat_if.dst                 scale,
  output logic                frame_done,
  output sub_mult_pkg::word_t rslt_tdata,
  output logic                rslt_tvalid,
  input  logic                rslt_tready,
  output logic                rslt_tlast
);

  localparam int WORD_W   = sub_mult_pkg::WORD_W;
  localparam int LANES    = sub_mult_pkg::NUM_LANES;
  localparam int PROD_W   = 2 * WORD_W;
  localparam int RSLT_LSB = FRAC_DATA + FRAC_SCALE - FRAC_RSLT;

  logic [LANES-1:0]    lane_valid;
  logic [LANES-1:0]    lane_last;
  logic [LANES-1:0]    lane_ready;
  sub_mult_pkg::word_t diff;
  logic [PROD_W-1:0]   diff_ext;
  logic [PROD_W-1:0]   scale_ext;
  logic [PROD_W-1:0]   prod;

  beat_if #(.DATA_W(WORD_W)) join_beat ();
  beat_if #(.DATA_W(WORD_W)) rslt_beat ();

  assign lane_valid[sub_mult_pkg::LANE_DATA]  = data.tvalid;
  assign lane_valid[sub_mult_pkg::LANE_GRID]  = grid.tvalid;
  assign lane_valid[sub_mult_pkg::LANE_SCALE] = scale.tvalid;
  assign lane_last[sub_mult_pkg::LANE_DATA]   = data.tlast;
  assign lane_last[sub_mult_pkg::LANE_GRID]   = grid.tlast;
  assign lane_last[sub_mult_pkg::LANE_SCALE]  = scale.tlast;

  // A lane is taken only together with the other two
  always_comb begin
    logic [LANES-1:0] others;
    others = '0;
    for (int i = 0; i < LANES; i++) begin
      others        = lane_valid;
      others[i]     = 1'b1;
      lane_ready[i] = join_beat.tready && (&others);
    end
  end

  assign data.tready  = lane_ready[sub_mult_pkg::LANE_DATA];
  assign grid.tready  = lane_ready[sub_mult_pkg::LANE_GRID];
  assign scale.tready = lane_ready[sub_mult_pkg::LANE_SCALE];

  // Difference wraps at word width before the multiply
  assign diff      = data.tdata - grid.tdata;
  assign diff_ext  = {{WORD_W{diff[WORD_W-1]}}, diff};
  assign scale_ext = {{WORD_W{scale.tdata[WORD_W-1]}}, scale.tdata};
  assign prod      = diff_ext * scale_ext;

  // Rescale by bit selection, floor and wrap
  assign join_beat.tdata  = prod[RSLT_LSB +: WORD_W];
  assign join_beat.tvalid = &lane_valid;
  assign join_beat.tlast  = &lane_last;

  assign frame_done = join_beat.tvalid && join_beat.tready && join_beat.tlast;

  axis_skid #(
    .DATA_W(WORD_W)
  ) u_rslt_skid (
    .clk   (clk),
    .arst_n(arst_n),
    .in    (join_beat.dst),
    .out   (rslt_beat.src)
  );

  assign rslt_tdata      = rslt_beat.tdata;
  assign rslt_tvalid     = rslt_beat.tvalid;
  assign rslt_tlast      = rslt_beat.tlast;
  assign rslt_beat.tready = rslt_tready;

endmodule

//--- verilog/sub_mult.sv
module sub_mult #(
  parameter int FRAC_DATA  = sub_mult_pkg::FRAC_DATA,
  parameter int FRAC_SCALE = sub_mult_pkg::FRAC_SCALE,
  parameter int FRAC_RSLT  = sub_mult_pkg::FRAC_RSLT
) (
  input  logic                clk,
  input  logic                arst_n,
  // Data stream
  input  sub_mult_pkg::word_t data_tdata,
  input  logic                data_tvalid,
  output logic                data_tready,
  input  logic                data_tlast,
  // Grid stream
  input  sub_mult_pkg::word_t grid_tdata,
  input  logic                grid_tvalid,
  output logic                grid_tready,
  input  logic                grid_tlast,
  // Scale stream
  input  sub_mult_pkg::word_t scale_tdata,
  input  logic                scale_tvalid,
  output logic                scale_tready,
  input  logic                scale_tlast,
  // Result stream
  output sub_mult_pkg::word_t rslt_tdata,
  output logic                rslt_tvalid,
  input  logic                rslt_tready,
  output logic                rslt_tlast
);

  localparam int LANES = sub_mult_pkg::NUM_LANES;

  logic frame_done;

  beat_if #(.DATA_W(sub_mult_pkg::WORD_W)) lane_in  [LANES] ();
  beat_if #(.DATA_W(sub_mult_pkg::WORD_W)) lane_out [LANES] ();

  assign lane_in[sub_mult_pkg::LANE_DATA].tdata   = data_tdata;
  assign lane_in[sub_mult_pkg::LANE_DATA].tvalid  = data_tvalid;
  assign lane_in[sub_mult_pkg::LANE_DATA].tlast   = data_tlast;
  assign data_tready = lane_in[sub_mult_pkg::LANE_DATA].tready;

  assign lane_in[sub_mult_pkg::LANE_GRID].tdata   = grid_tdata;
  assign lane_in[sub_mult_pkg::LANE_GRID].tvalid  = grid_tvalid;
  assign lane_in[sub_mult_pkg::LANE_GRID].tlast   = grid_tlast;
  assign grid_tready = lane_in[sub_mult_pkg::LANE_GRID].tready;

  assign lane_in[sub_mult_pkg::LANE_SCALE].tdata  = scale_tdata;
  assign lane_in[sub_mult_pkg::LANE_SCALE].tvalid = scale_tvalid;
  assign lane_in[sub_mult_pkg::LANE_SCALE].tlast  = scale_tlast;
  assign scale_tready = lane_in[sub_mult_pkg::LANE_SCALE].tready;

  // One skid lane per input stream
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    frame_lane #(
      .DATA_W(sub_mult_pkg::WORD_W)
    ) u_lane (
      .clk       (clk),
      .arst_n    (arst_n),
      .in        (lane_in[i]),
      .frame_done(frame_done),
      .out       (lane_out[i])
    );
  end

  sub_mult_join #(
    .FRAC_DATA (FRAC_DATA),
    .FRAC_SCALE(FRAC_SCALE),
    .FRAC_RSLT (FRAC_RSLT)
  ) u_join (
    .clk        (clk),
    .arst_n     (arst_n),
    .data       (lane_out[sub_mult_pkg::LANE_DATA]),
    .grid       (lane_out[sub_mult_pkg::LANE_GRID]),
    .scale      (lane_out[sub_mult_pkg::LANE_SCALE]),
    .frame_done (frame_done),
    .rslt_tdata (rslt_tdata),
    .rslt_tvalid(rslt_tvalid),
    .rslt_tready(rslt_tready),
    .rslt_tlast (rslt_tlast)
  );

endmodule

//--- dv/sub_mult_assertions.sv
module sub_mult_assertions (
  input logic                clk,
  input logic                arst_n,
  input sub_mult_pkg::word_t rslt_tdata,
  input logic                rslt_tvalid,
  input logic                rslt_tready,
  input logic                rslt_tlast
);

  int fail_count = 0;

  // No result leaves the block while reset is held
  idle_in_reset: assert property (
    @(posedge clk) !arst_n |-> !rslt_tvalid
  ) else begin
    $error("rslt_tvalid high while arst_n is low");
    fail_count++;
  end

  // Stalled beat keeps its payload
  steady_on_stall: assert property (
    @(posedge clk) disable iff (!arst_n)
    rslt_tvalid && !rslt_tready |=> rslt_tvalid && $stable(rslt_tdata) && $stable(rslt_tlast)
  ) else begin
    $error("result beat changed while rslt_tready was low");
    fail_count++;
  end

  last_with_valid: assert property (
    @(posedge clk) disable iff (!arst_n) rslt_tlast |-> rslt_tvalid
  ) else begin
    $error("rslt_tlast high without rslt_tvalid");
    fail_count++;
  end

endmodule

bind sub_mult sub_mult_assertions u_assertions (
  .clk        (clk),
  .arst_n     (arst_n),
  .rslt_tdata (rslt_tdata),
  .rslt_tvalid(rslt_tvalid),
  .rslt_tready(rslt_tready),
  .rslt_tlast (rslt_tlast)
);

//--- dv/sub_mult_tb.sv
module sub_mult_tb;

  localparam int LANES      = sub_mult_pkg::NUM_LANES;
  localparam int WORD_W     = sub_mult_pkg::WORD_W;
  localparam int SHIFT      = sub_mult_pkg::FRAC_DATA + sub_mult_pkg::FRAC_SCALE -
                              sub_mult_pkg::FRAC_RSLT;
  localparam int STIM_DEPTH = 512;
  localparam int MAX_BEATS  = 64;
  localparam int TIMEOUT    = 200;

  // Lane codes in the stimulus that are not beats
  localparam logic [15:0] TEST_MARK = 16'h000f;
  localparam logic [15:0] END_MARK  = 16'h000e;

  logic                clk;
  logic                arst_n;
  sub_mult_pkg::word_t in_tdata [LANES];
  logic [LANES-1:0]    in_tvalid;
  logic [LANES-1:0]    in_tlast;
  wire  [LANES-1:0]    in_tready;
  sub_mult_pkg::word_t rslt_tdata;
  logic                rslt_tvalid;
  logic                rslt_tready;
  logic                rslt_tlast;

  logic [15:0]         stim_mem [STIM_DEPTH];
  sub_mult_pkg::word_t lane_val [LANES][MAX_BEATS];
  logic                lane_last [LANES][MAX_BEATS];
  int                  lane_len [LANES];
  sub_mult_pkg::word_t exp_data [$];
  logic                exp_last [$];
  logic [31:0]         lcg_state;
  logic                mon_done;
  int                  tests;
  int                  checks;
  int                  errors;

  sub_mult #(
    .FRAC_DATA (sub_mult_pkg::FRAC_DATA),
    .FRAC_SCALE(sub_mult_pkg::FRAC_SCALE),
    .FRAC_RSLT (sub_mult_pkg::FRAC_RSLT)
  ) dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .data_tdata  (in_tdata[sub_mult_pkg::LANE_DATA]),
    .data_tvalid (in_tvalid[sub_mult_pkg::LANE_DATA]),
    .data_tready (in_tready[sub_mult_pkg::LANE_DATA]),
    .data_tlast  (in_tlast[sub_mult_pkg::LANE_DATA]),
    .grid_tdata  (in_tdata[sub_mult_pkg::LANE_GRID]),
    .grid_tvalid (in_tvalid[sub_mult_pkg::LANE_GRID]),
    .grid_tready (in_tready[sub_mult_pkg::LANE_GRID]),
    .grid_tlast  (in_tlast[sub_mult_pkg::LANE_GRID]),
    .scale_tdata (in_tdata[sub_mult_pkg::LANE_SCALE]),
    .scale_tvalid(in_tvalid[sub_mult_pkg::LANE_SCALE]),
    .scale_tready(in_tready[sub_mult_pkg::LANE_SCALE]),
    .scale_tlast (in_tlast[sub_mult_pkg::LANE_SCALE]),
    .rslt_tdata  (rslt_tdata),
    .rslt_tvalid (rslt_tvalid),
    .rslt_tready (rslt_tready),
    .rslt_tlast  (rslt_tlast)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // (data - grid) * scale in real fixed point, floored and wrapped to the word
  function automatic sub_mult_pkg::word_t expected_result(sub_mult_pkg::word_t d,
                                                          sub_mult_pkg::word_t g,
                                                          sub_mult_pkg::word_t s);
    sub_mult_pkg::word_t diff;
    longint              prod;
    longint              scaled;
    diff   = d - g;
    prod   = longint'(diff) * longint'(s);
    scaled = prod >>> SHIFT;
    return scaled[WORD_W-1:0];
  endfunction

  task automatic build_expected();
    int                  start [LANES];
    int                  stop [LANES];
    int                  span;
    sub_mult_pkg::word_t v [LANES];
    exp_data.delete();
    exp_last.delete();
    for (int l = 0; l < LANES; l++) begin
      start[l] = 0;
    end
    while (start[0] < lane_len[0]) begin
      span = 0;
      // Frame ends at the first tlast of each lane
      for (int l = 0; l < LANES; l++) begin
        stop[l] = start[l];
        while (stop[l] < lane_len[l] - 1 && !lane_last[l][stop[l]]) begin
          stop[l]++;
        end
        if (stop[l] - start[l] + 1 > span) begin
          span = stop[l] - start[l] + 1;
        end
      end
      // Shorter frames repeat their final beat
      for (int i = 0; i < span; i++) begin
        for (int l = 0; l < LANES; l++) begin
          v[l] = lane_val[l][(start[l] + i < stop[l]) ? start[l] + i : stop[l]];
        end
        exp_data.push_back(expected_result(v[sub_mult_pkg::LANE_DATA],
                                           v[sub_mult_pkg::LANE_GRID],
                                           v[sub_mult_pkg::LANE_SCALE]));
        exp_last.push_back(i == span - 1);
      end
      for (int l = 0; l < LANES; l++) begin
        start[l] = stop[l] + 1;
      end
    end
  endtask

  task automatic set_idle(input int lane);
    in_tvalid[lane] = 1'b0;
    in_tlast[lane]  = 1'b0;
    in_tdata[lane]  = '0;
  endtask

  task automatic drive_lane(input int lane, input bit gaps);
    logic [31:0] rnd;
    int          gap;
    int          wait_cycles;
    for (int i = 0; i < lane_len[lane]; i++) begin
      rnd = next_random();
      gap = gaps ? int'(rnd[17:16]) : 0;
      repeat (gap) begin
        @(negedge clk);
        set_idle(lane);
      end
      @(negedge clk);
      in_tdata[lane]  = lane_val[lane][i];
      in_tlast[lane]  = lane_last[lane][i];
      in_tvalid[lane] = 1'b1;
      wait_cycles = 0;
      do begin
        @(posedge clk);
        wait_cycles++;
      end while (!in_tready[lane] && wait_cycles < TIMEOUT);
      if (!in_tready[lane]) begin
        $display("timeout: lane %0d beat %0d was never accepted", lane, i);
        errors++;
        break;
      end
    end
    @(negedge clk);
    set_idle(lane);
  endtask

  // Back-pressure about one cycle in four while randomized
  task automatic drive_ready(input bit gaps);
    logic [31:0] rnd;
    while (!mon_done) begin
      @(negedge clk);
      rnd = next_random();
      rslt_tready = gaps ? (rnd[19:18] != 2'b00) : 1'b1;
    end
  endtask

  task automatic collect_results();
    int wait_cycles;
    for (int i = 0; i < exp_data.size(); i++) begin
      wait_cycles = 0;
      do begin
        @(posedge clk);
        wait_cycles++;
      end while (!(rslt_tvalid && rslt_tready) && wait_cycles < TIMEOUT);
      if (!(rslt_tvalid && rslt_tready)) begin
        $display("timeout: result beat %0d of %0d never arrived", i, exp_data.size());
        errors++;
        break;
      end
      checks++;
      assert (rslt_tdata === exp_data[i]) else begin
        $display("mismatch rslt_tdata: beat %0d expected %h got %h", i, exp_data[i], rslt_tdata);
        errors++;
      end
      assert (rslt_tlast === exp_last[i]) else begin
        $display("mismatch rslt_tlast: beat %0d expected %h got %h", i, exp_last[i], rslt_tlast);
        errors++;
      end
    end
    mon_done = 1'b1;
  endtask

  task automatic run_test(input int id, input int rounds);
    int errors_before;
    int passes;
    bit gaps;
    errors_before = errors;
    gaps          = (rounds != 0);
    passes        = gaps ? rounds : 1;
    build_expected();
    for (int r = 0; r < passes; r++) begin
      mon_done = 1'b0;
      fork
        drive_lane(sub_mult_pkg::LANE_DATA, gaps);
        drive_lane(sub_mult_pkg::LANE_GRID, gaps);
        drive_lane(sub_mult_pkg::LANE_SCALE, gaps);
        drive_ready(gaps);
        collect_results();
      join
      // Output stays quiet once every frame is out
      @(negedge clk);
      rslt_tready = 1'b1;
      repeat (8) begin
        @(posedge clk);
        assert (!rslt_tvalid) else begin
          $display("extra result beat after the end of test %0d", id);
          errors++;
        end
      end
    end
    tests++;
    $display("test %0d done: %0d round(s) of %0d beats, %0d errors",
             id, passes, exp_data.size(), errors - errors_before);
  endtask

  initial begin
    int          idx;
    int          test_id;
    int          rounds;
    bit          have_test;
    logic [15:0] lane;
    arst_n      = 1'b0;
    rslt_tready = 1'b0;
    lcg_state   = 32'hf60c;
    mon_done    = 1'b0;
    tests       = 0;
    checks      = 0;
    errors      = 0;
    for (int l = 0; l < LANES; l++) begin
      set_idle(l);
      lane_len[l] = 0;
    end
    $readmemh("dv/sub_mult_stimulus.txt", stim_mem);

    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(posedge clk);
    assert (rslt_tvalid === 1'b0) else begin
      $display("mismatch rslt_tvalid: expected 0 got %h", rslt_tvalid);
      errors++;
    end
    assert (in_tready === '0) else begin
      $display("mismatch in_tready: expected 0 got %h", in_tready);
      errors++;
    end
    // Input readies come up one cycle after reset release
    @(negedge clk);
    assert (in_tready === {LANES{1'b1}}) else begin
      $display("mismatch in_tready: expected %h got %h", {LANES{1'b1}}, in_tready);
      errors++;
    end

    idx       = 0;
    test_id   = 0;
    rounds    = 0;
    have_test = 1'b0;
    while (idx + 2 < STIM_DEPTH && !$isunknown(stim_mem[idx]) && stim_mem[idx] != END_MARK) begin
      lane = stim_mem[idx];
      if (lane == TEST_MARK) begin
        if (have_test) begin
          run_test(test_id, rounds);
        end
        test_id   = stim_mem[idx+1];
        rounds    = stim_mem[idx+2];
        have_test = 1'b1;
        for (int l = 0; l < LANES; l++) begin
          lane_len[l] = 0;
        end
      end else if (lane < LANES) begin
        lane_val[lane][lane_len[lane]]  = stim_mem[idx+1];
        lane_last[lane][lane_len[lane]] = stim_mem[idx+2][0];
        lane_len[lane]++;
      end else begin
        $display("stimulus line %0d names an unknown lane %h", idx / 3, lane);
        errors++;
      end
      idx += 3;
    end
    if (have_test) begin
      run_test(test_id, rounds);
    end

    errors += dut.u_assertions.fail_count;
    $display("tests %0d, result beats %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- files.f
verilog/sub_mult_pkg.sv
verilog/beat_if.sv
verilog/axis_skid.sv
verilog/frame_lane.sv
verilog/sub_mult_join.sv
verilog/sub_mult.sv
dv/sub_mult_assertions.sv
dv/sub_mult_tb.sv

//--- Bender.yml
package:
  name: sub_mult

sources:
  - verilog/sub_mult_pkg.sv
  - verilog/beat_if.sv
  - verilog/axis_skid.sv
  - verilog/frame_lane.sv
  - verilog/sub_mult_join.sv
  - verilog/sub_mult.sv
  - target: simulation
    files:
      - dv/sub_mult_assertions.sv
      - dv/sub_mult_tb.sv

//--- dv/sub_mult_stimulus.txt
// Each line holds lane, value and last flag in hex, lanes 0 to 2 are data, grid and scale
// Lane f opens a test with its id and round count (0 runs once with no gaps)
// Lane e closes the file
f 0001 0
0 3000 0
0 2800 1
1 1000 0
1 0800 1
2 0800 0
2 2000 1
f 0002 0
0 0800 0
0 7000 0
0 0001 1
1 2000 0
1 9000 0
1 0000 1
2 1800 0
2 c000 0
2 ffff 1
f 0003 0
0 1000 0
0 2000 0
0 3000 1
1 0400 1
2 1000 0
2 f000 1
f 0004 0
0 1800 1
0 0c00 0
0 f400 1
1 0200 0
1 0600 1
1 fe00 1
2 1000 1
2 0400 1
f 0005 4
0 1000 0
0 5000 1
0 e000 1
1 2000 1
1 0100 0
1 0300 1
2 2000 0
2 0800 1
2 f800 0
2 4000 1
e 0000 0
